// ==== tanh_pkg.sv ====
// Q4.12 types, tanh segment constants, controller state enum, scalar command struct
package tanh_pkg;

  //////////////////////////////////////////////////
  // Fixed-point format
  //////////////////////////////////////////////////

  // Signed Q4.12 sample, 1.0 is 0x1000
  typedef logic signed [15:0] fix_t;
  // Unsigned magnitude of a sample
  typedef logic [15:0] mag_t;
  // Shift-add step index
  typedef logic [4:0] step_t;

  localparam mag_t FIX_ONE = 16'h1000;

  //////////////////////////////////////////////////
  // Piecewise-linear segments
  //////////////////////////////////////////////////

  // Segment boundaries on |x|
  localparam mag_t HALF_THRESH  = 16'h0800;
  localparam mag_t ONE_THRESH   = 16'h1000;
  localparam mag_t THREE_THRESH = 16'h3000;

  // Slopes 7/8, 5/8, 1/8
  localparam mag_t SLOPE_LOW  = 16'h0E00;
  localparam mag_t SLOPE_MID  = 16'h0A00;
  localparam mag_t SLOPE_HIGH = 16'h0200;

  // Offsets 0.125 and 0.625, lowest segment has none
  localparam mag_t OFFSET_MID  = 16'h0200;
  localparam mag_t OFFSET_HIGH = 16'h0A00;

  // One step per multiplier bit
  localparam step_t MUL_STEPS = 5'd16;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    idle_st,
    input_st,
    wait_st
  } ctrl_state_e;

  // Launch for the scalar unit
  typedef struct packed {
    logic start;
    fix_t operand;
  } scalar_cmd_t;

endpackage

// ==== tanh_element_counter.sv ====
// Element index counter with last-element and empty-vector flags
`timescale 1ns/10ps

module tanh_element_counter #(
  parameter int COUNT_W = 8
) (
  input  logic               CLK,
  input  logic               RST,
  input  logic               cnt_clear,
  input  logic               cnt_incr,
  input  logic [COUNT_W-1:0] size_in,
  output logic               is_last,
  output logic               is_empty
);

  //////////////////////////////////////////////////
  // Index and job length
  //////////////////////////////////////////////////

  // Position of the element in flight
  logic [COUNT_W-1:0] index;
  // Length captured at job start
  logic [COUNT_W-1:0] size_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      index  <= '0;
      size_q <= '0;
    end else if (cnt_clear) begin
      // New job, length frozen from here on
      index  <= '0;
      size_q <= size_in;
    end else if (cnt_incr) begin
      index <= index + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Flags
  //////////////////////////////////////////////////

  // Last element of the frozen length
  assign is_last = (index == (size_q - 1'b1));

  // Decided at start time, so taken from the live length
  assign is_empty = (size_in == '0);

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Index stays within the job after any increment
  a_index_bound: assert property (@(posedge CLK) disable iff (RST)
    cnt_incr |=> (index <= (size_q - 1'b1)));

endmodule

// ==== tanh_scalar_unit.sv ====
// Scalar tanh: segment select, serial shift-add multiply, offset, clamp, sign restore
`timescale 1ns/10ps

module tanh_scalar_unit
  import tanh_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  scalar_cmd_t cmd,
  output logic        done,
  output fix_t        result
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    sc_idle,
    sc_select,
    sc_mult,
    sc_finish
  } scalar_phase_e;

  scalar_phase_e phase;
  step_t         step_cnt;

  // Operand magnitude and sign
  mag_t abs_in;
  mag_t mag_q;
  logic neg_q;

  // Segment parameters
  mag_t slope_sel;
  mag_t offset_sel;
  mag_t offset_q;

  // Shift-add datapath
  logic [31:0] acc;
  logic [31:0] mcand;
  mag_t        mult;

  // Output stage
  mag_t        prod_q412;
  logic [16:0] sum;
  mag_t        clamped;

  //////////////////////////////////////////////////
  // Magnitude and segment
  //////////////////////////////////////////////////

  // Most negative value has no positive twin
  always_comb begin
    if (!cmd.operand[15]) begin
      abs_in = mag_t'(cmd.operand);
    end else if (cmd.operand == {1'b1, 15'd0}) begin
      abs_in = 16'h7FFF;
    end else begin
      abs_in = mag_t'(-cmd.operand);
    end
  end

  always_comb begin
    if (mag_q < HALF_THRESH) begin
      slope_sel  = SLOPE_LOW;
      offset_sel = '0;
    end else if (mag_q < ONE_THRESH) begin
      slope_sel  = SLOPE_MID;
      offset_sel = OFFSET_MID;
    end else if (mag_q < THREE_THRESH) begin
      slope_sel  = SLOPE_HIGH;
      offset_sel = OFFSET_HIGH;
    end else begin
      // Flat at 1.0, product drops out
      slope_sel  = '0;
      offset_sel = FIX_ONE;
    end
  end

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  // 1 select + 16 steps + 1 finish after the start edge
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase    <= sc_idle;
      step_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (phase)
        sc_idle: begin
          if (cmd.start) begin
            phase <= sc_select;
          end
        end
        sc_select: begin
          step_cnt <= '0;
          phase    <= sc_mult;
        end
        sc_mult: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == (MUL_STEPS - 1'b1)) begin
            phase <= sc_finish;
          end
        end
        sc_finish: begin
          done  <= 1'b1;
          phase <= sc_idle;
        end
        default: begin
          phase <= sc_idle;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // Back to Q4.12 by truncation, then offset
  assign prod_q412 = mag_t'(acc >> 12);
  assign sum       = {1'b0, prod_q412} + {1'b0, offset_q};
  assign clamped   = (sum > {1'b0, FIX_ONE}) ? FIX_ONE : sum[15:0];

  always_ff @(posedge CLK) begin
    case (phase)
      sc_idle: begin
        if (cmd.start) begin
          mag_q <= abs_in;
          neg_q <= cmd.operand[15];
        end
      end
      sc_select: begin
        acc      <= '0;
        mcand    <= {16'd0, mag_q};
        mult     <= slope_sel;
        offset_q <= offset_sel;
      end
      sc_mult: begin
        // LSB first, multiplicand walks left
        if (mult[0]) begin
          acc <= acc + mcand;
        end
        mcand <= mcand << 1;
        mult  <= mult >> 1;
      end
      sc_finish: begin
        result <= neg_q ? -fix_t'(clamped) : fix_t'(clamped);
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // No new launch while an element is in flight
  a_no_start_busy: assert property (@(posedge CLK) disable iff (RST)
    cmd.start |-> (phase == sc_idle));

  // Full step count, done seen 19 sampling edges after start
  a_done_timing: assert property (@(posedge CLK) disable iff (RST)
    $rose(done) |-> (step_cnt == MUL_STEPS) && $past(cmd.start, 19));

endmodule

// ==== tanh_vector_ctrl.sv ====
// Vector job FSM: element intake, scalar launch, output strobes and ready pulse
`timescale 1ns/10ps

module tanh_vector_ctrl
  import tanh_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  // Job control
  input  logic        start,
  input  logic        data_in_enable,
  input  fix_t        data_in,
  // From element counter
  input  logic        is_last,
  input  logic        is_empty,
  // From scalar unit
  input  logic        done,
  input  fix_t        result,
  // To element counter
  output logic        cnt_clear,
  output logic        cnt_incr,
  // To scalar unit
  output scalar_cmd_t cmd,
  // Result side
  output logic        data_out_enable,
  output logic        ready,
  output fix_t        data_out
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  ctrl_state_e state;

  // Launch pulse, one cycle after the element strobe
  logic cmd_start;
  // Element held for the scalar unit
  fix_t operand;

  //////////////////////////////////////////////////
  // Counter control
  //////////////////////////////////////////////////

  // Clear and latch length on any accepted start
  assign cnt_clear = (state == idle_st) && start;

  // Advance on every finished element but the last
  assign cnt_incr = (state == wait_st) && done && !is_last;

  assign cmd = '{start: cmd_start, operand: operand};

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= idle_st;
      cmd_start       <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
      data_out        <= '0;
    end else begin
      // Single-cycle pulses
      cmd_start       <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;

      case (state)
        idle_st: begin
          if (start) begin
            // Zero length finishes at once
            if (is_empty) begin
              ready <= 1'b1;
            end else begin
              state <= input_st;
            end
          end
        end
        input_st: begin
          // One element in flight at a time
          if (data_in_enable) begin
            cmd_start <= 1'b1;
            state     <= wait_st;
          end
        end
        wait_st: begin
          if (done) begin
            data_out        <= result;
            data_out_enable <= 1'b1;
            if (is_last) begin
              // Ready shares the cycle of the last strobe
              ready <= 1'b1;
              state <= idle_st;
            end else begin
              state <= input_st;
            end
          end
        end
        default: begin
          state <= idle_st;
        end
      endcase
    end
  end

  // Operand register
  always_ff @(posedge CLK) begin
    if ((state == input_st) && data_in_enable) begin
      operand <= data_in;
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Launch only follows an element accepted in input_st
  a_start_from_input: assert property (@(posedge CLK) disable iff (RST)
    cmd.start |-> ($past(state) == input_st) && (state == wait_st));

  // Ready comes with the last strobe or right after an empty start
  a_ready_source: assert property (@(posedge CLK) disable iff (RST)
    ready |-> data_out_enable || $past((state == idle_st) && start && is_empty));

endmodule

// ==== tanh_vector_top.sv ====
// Vector tanh engine top: controller, element counter and scalar unit
`timescale 1ns/10ps

module tanh_vector_top
  import tanh_pkg::*;
#(
  parameter int COUNT_W = 8
) (
  input  logic               CLK,
  input  logic               RST,
  // Job control
  input  logic               start,
  input  logic [COUNT_W-1:0] size_in,
  // Element input
  input  logic               data_in_enable,
  input  fix_t               data_in,
  // Element output
  output logic               data_out_enable,
  output fix_t               data_out,
  output logic               ready
);

  //////////////////////////////////////////////////
  // Internal wiring
  //////////////////////////////////////////////////

  // Controller to counter
  logic cnt_clear;
  logic cnt_incr;
  logic is_last;
  logic is_empty;

  // Controller to scalar unit
  scalar_cmd_t cmd;
  logic        done;
  fix_t        result;

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  tanh_vector_ctrl u_ctrl (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .data_in_enable  (data_in_enable),
    .data_in         (data_in),
    .is_last         (is_last),
    .is_empty        (is_empty),
    .done            (done),
    .result          (result),
    .cnt_clear       (cnt_clear),
    .cnt_incr        (cnt_incr),
    .cmd             (cmd),
    .data_out_enable (data_out_enable),
    .ready           (ready),
    .data_out        (data_out)
  );

  // Length goes straight to the counter
  tanh_element_counter #(
    .COUNT_W (COUNT_W)
  ) u_counter (
    .CLK       (CLK),
    .RST       (RST),
    .cnt_clear (cnt_clear),
    .cnt_incr  (cnt_incr),
    .size_in   (size_in),
    .is_last   (is_last),
    .is_empty  (is_empty)
  );

  tanh_scalar_unit u_scalar (
    .CLK    (CLK),
    .RST    (RST),
    .cmd    (cmd),
    .done   (done),
    .result (result)
  );

endmodule

// ==== tb_tanh_vector.sv ====
// Testbench for the vector tanh engine: clock, reset, LCG stimulus, tanh model, assertions
`timescale 1ns/10ps

module tb_tanh_vector
  import tanh_pkg::*;
;

  //////////////////////////////////////////////////
  // Constants and types
  //////////////////////////////////////////////////

  // Edges from input sample to output launch
  localparam int OUT_LATENCY = 20;
  // Cycles allowed for any single wait
  localparam int OUT_TIMEOUT = 100;

  // One expected result
  typedef struct packed {
    logic        last;
    fix_t        value;
    logic [31:0] in_edge;
  } exp_t;

  //////////////////////////////////////////////////
  // DUT signals and testbench state
  //////////////////////////////////////////////////

  logic       CLK;
  logic       RST;
  logic       start;
  logic [7:0] size_in;
  logic       data_in_enable;
  fix_t       data_in;
  logic       data_out_enable;
  fix_t       data_out;
  logic       ready;

  // Results still owed by the DUT, head kept apart for the assertions
  exp_t        exp_q[$];
  exp_t        exp_head;
  logic        exp_valid;
  fix_t        job_ops[$];
  fix_t        boundary_ops[15];
  logic [31:0] lcg_state;
  // Start with a zero length in the current cycle
  logic        empty_start;
  logic        job_seen;
  int          edge_cnt;
  int          out_cnt;
  int          ready_cnt;
  int          errors;

  tanh_vector_top #(
    .COUNT_W (8)
  ) u_tanh_vector_top (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .size_in         (size_in),
    .data_in_enable  (data_in_enable),
    .data_in         (data_in),
    .data_out_enable (data_out_enable),
    .data_out        (data_out),
    .ready           (ready)
  );

  // 40 ns period
  always #20 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Stimulus source and model
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Piecewise-linear tanh on Q4.12, sign restored afterwards
  function automatic fix_t tanh_model(input fix_t x);
    mag_t        m;
    mag_t        slope;
    mag_t        offset;
    logic [31:0] prod;
    logic [16:0] y;
    if (x == fix_t'(16'h8000)) begin
      m = 16'h7FFF;
    end else if (x < 0) begin
      m = mag_t'(-x);
    end else begin
      m = mag_t'(x);
    end
    if (m < HALF_THRESH) begin
      slope  = SLOPE_LOW;
      offset = 16'h0000;
    end else if (m < ONE_THRESH) begin
      slope  = SLOPE_MID;
      offset = OFFSET_MID;
    end else begin
      slope  = SLOPE_HIGH;
      offset = OFFSET_HIGH;
    end
    prod = 32'(m) * 32'(slope);
    y    = 17'(prod >> 12) + 17'(offset);
    // Flat segment and any overshoot end at 1.0
    if ((m >= THREE_THRESH) || (y > 17'(FIX_ONE))) begin
      y = 17'(FIX_ONE);
    end
    return (x < 0) ? -fix_t'(y[15:0]) : fix_t'(y[15:0]);
  endfunction

  //////////////////////////////////////////////////
  // Expected-result queue
  //////////////////////////////////////////////////

  task automatic push_expected(input exp_t e);
    exp_q.push_back(e);
    if (!exp_valid) begin
      exp_head  = e;
      exp_valid = 1'b1;
    end
  endtask

  task automatic pop_expected();
    if (exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
    if (exp_q.size() > 0) begin
      exp_head = exp_q[0];
    end else begin
      exp_valid = 1'b0;
    end
  endtask

  // Edge count, output count and latency per result
  always @(posedge CLK) begin
    edge_cnt = edge_cnt + 1;
    if (ready) begin
      ready_cnt++;
    end
    if (data_out_enable) begin
      out_cnt++;
      if (exp_valid) begin
        // Launch edge is the one before this sample
        a_latency: assert ((edge_cnt - 1 - int'(exp_head.in_edge)) == OUT_LATENCY)
        else begin
          errors++;
          $display("ERR data_out_enable latency expected %h actual %h",
                   OUT_LATENCY, edge_cnt - 1 - int'(exp_head.in_edge));
        end
      end
      pop_expected();
    end
  end

  //////////////////////////////////////////////////
  // Concurrent checks
  //////////////////////////////////////////////////

  a_quiet_reset: assert property (@(posedge CLK) disable iff (RST)
    !job_seen |-> !ready && !data_out_enable && (data_out == 16'h0000))
  else begin
    errors++;
    $display("Output activity seen before the first job");
  end

  a_out_owed: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> exp_valid)
  else begin
    errors++;
    $display("Output strobe with no element in flight");
  end

  a_out_value: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable && exp_valid |-> (data_out == exp_head.value))
  else begin
    errors++;
    $display("ERR data_out expected %h actual %h",
             $sampled(exp_head.value), $sampled(data_out));
  end

  // Ready only on the job's last element
  a_ready_last: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable && exp_valid |-> (ready == exp_head.last))
  else begin
    errors++;
    $display("ERR ready expected %h actual %h", $sampled(exp_head.last), $sampled(ready));
  end

  a_ready_source: assert property (@(posedge CLK) disable iff (RST)
    ready |-> data_out_enable || $past(empty_start))
  else begin
    errors++;
    $display("Ready pulse with no last element and no empty start");
  end

  a_empty_ready: assert property (@(posedge CLK) disable iff (RST)
    empty_start |=> ready && !data_out_enable)
  else begin
    errors++;
    $display("Empty job did not give a lone ready pulse one cycle after start");
  end

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  task automatic abort_run(input string what);
    errors++;
    $display("Timeout waiting for %s", what);
    $display("Checks done, %0d errors", errors);
    $display("Test failures found");
    $finish;
  endtask

  task automatic start_job(input logic [7:0] size);
    start       = 1'b1;
    size_in     = size;
    empty_start = (size == 8'd0);
    job_seen    = 1'b1;
    @(negedge CLK);
    start       = 1'b0;
    empty_start = 1'b0;
  endtask

  // One element, then wait for its result with optional noise on the inputs
  task automatic send_element(input fix_t x, input logic last, input bit noisy);
    logic [31:0] r;
    exp_t        e;
    int          gap;
    int          t;
    r   = lcg_next();
    gap = int'(r[31:30]);
    repeat (gap) @(negedge CLK);
    data_in_enable = 1'b1;
    data_in        = x;
    e.last         = last;
    e.value        = tanh_model(x);
    e.in_edge      = 32'(edge_cnt + 1);
    push_expected(e);
    @(negedge CLK);
    data_in_enable = 1'b0;
    t = 0;
    while (!data_out_enable && (t < OUT_TIMEOUT)) begin
      // Stray strobes and starts while busy
      if (noisy) begin
        r              = lcg_next();
        data_in_enable = r[31];
        start          = r[30];
        size_in        = r[23:16];
        data_in        = fix_t'(r[15:0]);
      end
      @(negedge CLK);
      t++;
    end
    data_in_enable = 1'b0;
    start          = 1'b0;
    if (!data_out_enable) begin
      abort_run("data_out_enable of an element");
    end
  endtask

  task automatic run_job(input bit noisy);
    int n;
    int outs0;
    int readys0;
    int i;
    n       = job_ops.size();
    outs0   = out_cnt;
    readys0 = ready_cnt;
    start_job(8'(n));
    for (i = 0; i < n; i++) begin
      send_element(job_ops[i], (i == n - 1), noisy);
    end
    // Let the last strobe be counted
    @(negedge CLK);
    a_job_count: assert ((out_cnt - outs0) == n)
    else begin
      errors++;
      $display("ERR out_cnt expected %h actual %h", n, out_cnt - outs0);
    end
    a_job_ready: assert ((ready_cnt - readys0) == 1)
    else begin
      errors++;
      $display("ERR ready_cnt expected %h actual %h", 1, ready_cnt - readys0);
    end
  endtask

  task automatic run_empty_job();
    int outs0;
    int readys0;
    int t;
    outs0   = out_cnt;
    readys0 = ready_cnt;
    start_job(8'd0);
    t = 0;
    while (!ready && (t < OUT_TIMEOUT)) begin
      @(negedge CLK);
      t++;
    end
    if (!ready) begin
      abort_run("ready after an empty start");
    end
    @(negedge CLK);
    a_empty_count: assert ((ready_cnt - readys0 == 1) && (out_cnt == outs0))
    else begin
      errors++;
      $display("ERR ready_cnt expected %h actual %h", 1, ready_cnt - readys0);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int i;
    CLK            = 1'b0;
    RST            = 1'b1;
    start          = 1'b0;
    size_in        = 8'd0;
    data_in_enable = 1'b0;
    data_in        = 16'h0000;
    empty_start    = 1'b0;
    job_seen       = 1'b0;
    exp_valid      = 1'b0;
    exp_head       = '0;
    lcg_state      = 32'd97;
    edge_cnt       = 0;
    out_cnt        = 0;
    ready_cnt      = 0;
    errors         = 0;
    // Both sides of every segment edge, saturation and the sign
    boundary_ops = '{16'h0000, 16'h07FF, 16'hF801, 16'h0800, 16'hF800,
                     16'h0FFF, 16'hF001, 16'h1000, 16'hF000, 16'h2FFF,
                     16'hD001, 16'h3000, 16'hD000, 16'h7FFF, 16'h8000};
    repeat (4) @(negedge CLK);
    RST = 1'b0;
    // Outputs stay quiet before any job
    repeat (5) @(negedge CLK);

    job_ops.delete();
    for (i = 0; i < 15; i++) begin
      job_ops.push_back(boundary_ops[i]);
    end
    run_job(1'b0);

    run_empty_job();

    job_ops.delete();
    for (i = 0; i < 40; i++) begin
      job_ops.push_back(fix_t'(lcg_next() >> 16));
    end
    run_job(1'b0);

    // Noise on the inputs while elements are in flight
    job_ops.delete();
    for (i = 0; i < 12; i++) begin
      job_ops.push_back(fix_t'(lcg_next() >> 16));
    end
    run_job(1'b1);

    run_empty_job();
    repeat (3) @(negedge CLK);

    $display("Checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== build.f ====
tanh_pkg.sv
tanh_element_counter.sv
tanh_scalar_unit.sv
tanh_vector_ctrl.sv
tanh_vector_top.sv
tb_tanh_vector.sv
